//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_core_exec_unit
FILELIST  = compile.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- compile.f
logic/core_pkg.sv
logic/alu_req_if.sv
logic/core_pipe_decode.sv
logic/core_req_queue.sv
logic/core_pipe_exec_alu.sv
logic/core_pipe_exec.sv
logic/core_exec_unit.sv
verif/core_exec_unit_assertions.sv
verif/tb_core_exec_unit.sv

//--- logic/alu_req_if.sv
/*
 * Decoded ALU request channel
 * Carries one decoded request with a valid/ready handshake
 */
interface alu_req_if
    import core_pkg::*;
();

    logic     valid;   // Request present
    logic     ready;   // Receiver can take it
    alu_req_t req;

    // Side that offers requests
    modport producer (
        output valid,
        output req,
        input  ready
    );

    // Side that takes requests
    modport consumer (
        input  valid,
        input  req,
        output ready
    );

endinterface

//--- logic/core_exec_unit.sv
/*
 * Integer execute unit
 * Decoder, request queue and execute stage joined by request channels
 */
module core_exec_unit
    import core_pkg::*;
(
    input  logic        g_clk,
    input  logic        rst,
    // Request side
    input  logic        in_valid,
    output logic        in_ready,
    input  alu_op_e     in_op,
    input  xlen_t       in_opr_a,
    input  xlen_t       in_opr_b,
    input  logic [5:0]  in_shamt,
    input  logic        in_word,
    input  tag_t        in_tag,
    // Result side
    output logic        out_valid,
    input  logic        out_ready,
    output xlen_t       out_result,
    output xlen_t       out_add,
    output cmp_flags_t  out_flags,
    output tag_t        out_tag
);

    alu_req_if dec_q ();    // Decoder to queue
    alu_req_if q_exec ();   // Queue to execute stage

    core_pipe_decode decode_inst (
        .op      (in_op),
        .opr_a   (in_opr_a),
        .opr_b   (in_opr_b),
        .shamt   (in_shamt),
        .word    (in_word),
        .tag     (in_tag),
        .valid   (in_valid),
        .ready   (in_ready),
        .req_out (dec_q.producer)
    );

    core_req_queue queue_inst (
        .g_clk (g_clk),
        .rst   (rst),
        .push  (dec_q.consumer),
        .pop   (q_exec.producer)
    );

    core_pipe_exec exec_inst (
        .g_clk      (g_clk),
        .rst        (rst),
        .req_in     (q_exec.consumer),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_result (out_result),
        .out_add    (out_add),
        .out_flags  (out_flags),
        .out_tag    (out_tag)
    );

endmodule

//--- logic/core_pipe_decode.sv
/*
 * ALU request decoder
 * Turns an opcode into one-hot ALU selects and drops word and shift
 * amount where the operation has no use for them
 */
module core_pipe_decode
    import core_pkg::*;
(
    input  alu_op_e           op,
    input  xlen_t             opr_a,
    input  xlen_t             opr_b,
    input  logic [5:0]        shamt,
    input  logic              word,
    input  tag_t              tag,
    input  logic              valid,
    output logic              ready,
    alu_req_if.producer       req_out
);

    alu_sel_t   sel;
    logic       keep_word;   // Operation has a word form
    logic       use_shamt;   // Operation reads shamt
    logic [5:0] shamt_c;

    always_comb begin
        sel           = '0;
        sel.op_add    = (op == ALU_ADD);
        sel.op_sub    = (op == ALU_SUB);
        sel.op_slt    = (op == ALU_SLT);
        sel.op_sltu   = (op == ALU_SLTU);
        sel.op_xor    = (op == ALU_XOR);
        sel.op_or     = (op == ALU_OR);
        sel.op_and    = (op == ALU_AND);
        sel.op_xorn   = (op == ALU_XORN);
        sel.op_orn    = (op == ALU_ORN);
        sel.op_andn   = (op == ALU_ANDN);
        sel.op_sll    = (op == ALU_SLL);
        sel.op_srl    = (op == ALU_SRL);
        sel.op_sra    = (op == ALU_SRA);
        sel.op_rol    = (op == ALU_ROL);
        sel.op_ror    = (op == ALU_ROR);
        sel.op_pack   = (op == ALU_PACK);
        sel.op_packu  = (op == ALU_PACKU);
        sel.op_packh  = (op == ALU_PACKH);
        sel.op_grev   = (op == ALU_GREV);
        sel.op_xpermn = (op == ALU_XPERMN);
        sel.op_xpermb = (op == ALU_XPERMB);

        // Shifts and rotates
        use_shamt = sel.op_sll || sel.op_srl || sel.op_sra || sel.op_rol || sel.op_ror;

        keep_word = sel.op_add || sel.op_sub || use_shamt ||
                    sel.op_pack || sel.op_packu;

        use_shamt = use_shamt || sel.op_grev;   // grev takes its pattern here

        sel.word  = word && keep_word;
        shamt_c   = use_shamt ? shamt : 6'd0;
    end

    // Pure pass-through handshake, no storage here
    assign req_out.valid = valid;
    assign ready         = req_out.ready;

    assign req_out.req = '{
        sel:   sel,
        opr_a: opr_a,
        opr_b: opr_b,
        shamt: shamt_c,
        tag:   tag
    };

endmodule

//--- logic/core_pipe_exec.sv
/*
 * Execute stage
 * Pops decoded requests, runs the ALU and holds each result in a
 * one-entry output register until it is taken
 */
module core_pipe_exec
    import core_pkg::*;
(
    input  logic          g_clk,
    input  logic          rst,
    alu_req_if.consumer   req_in,
    output logic          out_valid,
    input  logic          out_ready,
    output xlen_t         out_result,
    output xlen_t         out_add,
    output cmp_flags_t    out_flags,
    output tag_t          out_tag
);

    alu_sel_t sel;
    xlen_t    alu_result;
    xlen_t    alu_add;
    logic     alu_eq, alu_lt, alu_ltu;
    logic     take;        // Pop this cycle

    assign sel = req_in.req.sel;

    core_pipe_exec_alu alu_inst (
        .opr_a     (req_in.req.opr_a),
        .opr_b     (req_in.req.opr_b),
        .shamt     (req_in.req.shamt),
        .word      (sel.word),
        .op_add    (sel.op_add),
        .op_sub    (sel.op_sub),
        .op_xor    (sel.op_xor),
        .op_or     (sel.op_or),
        .op_and    (sel.op_and),
        .op_slt    (sel.op_slt),
        .op_sltu   (sel.op_sltu),
        .op_srl    (sel.op_srl),
        .op_sll    (sel.op_sll),
        .op_sra    (sel.op_sra),
        .op_xorn   (sel.op_xorn),
        .op_andn   (sel.op_andn),
        .op_orn    (sel.op_orn),
        .op_ror    (sel.op_ror),
        .op_rol    (sel.op_rol),
        .op_pack   (sel.op_pack),
        .op_packh  (sel.op_packh),
        .op_packu  (sel.op_packu),
        .op_grev   (sel.op_grev),
        .op_xpermn (sel.op_xpermn),
        .op_xpermb (sel.op_xpermb),
        .add_out   (alu_add),
        .cmp_eq    (alu_eq),
        .cmp_lt    (alu_lt),
        .cmp_ltu   (alu_ltu),
        .result    (alu_result)
    );

    // Free slot when empty or being drained now
    assign req_in.ready = !out_valid || out_ready;
    assign take         = req_in.valid && req_in.ready;

    always_ff @(posedge g_clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (take) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge g_clk) begin
        if (take) begin
            out_result <= alu_result;
            out_add    <= alu_add;
            out_flags  <= '{eq: alu_eq, lt: alu_lt, ltu: alu_ltu};
            out_tag    <= req_in.req.tag;
        end
    end

endmodule

//--- logic/core_pipe_exec_alu.sv
/*
 * Integer ALU
 * 64-bit arithmetic, compare, logic, shift and bit-manipulation unit,
 * purely combinational with one-hot operation selects
 */
module core_pipe_exec_alu
    import core_pkg::*;
(
    input  logic [XL:0] opr_a,      // Operand A
    input  logic [XL:0] opr_b,      // Operand B
    input  logic [5:0]  shamt,      // Shift amount or grev pattern
    input  logic        word,       // Use low 32 bits
    input  logic        op_add,
    input  logic        op_sub,
    input  logic        op_xor,
    input  logic        op_or,
    input  logic        op_and,
    input  logic        op_slt,
    input  logic        op_sltu,
    input  logic        op_srl,
    input  logic        op_sll,
    input  logic        op_sra,
    input  logic        op_xorn,
    input  logic        op_andn,
    input  logic        op_orn,
    input  logic        op_ror,
    input  logic        op_rol,
    input  logic        op_pack,
    input  logic        op_packh,
    input  logic        op_packu,
    input  logic        op_grev,
    input  logic        op_xpermn,
    input  logic        op_xpermb,
    output logic [XL:0] add_out,    // Raw adder output
    output logic        cmp_eq,
    output logic        cmp_lt,
    output logic        cmp_ltu,
    output logic [XL:0] result
);

    logic [XL:0]       opr_b_n;
    logic [XL:0]       add_res, slt_res, bit_res, shift_res, pack_res;
    logic [XL:0]       grev_7, grev_24, grev_56, grev_res;
    logic [XL:0]       xpn_res, xpb_res;
    logic [2*XLEN-1:0] rsh_in, rsh_out, lsh_in, lsh_out;
    logic [5:0]        sh_amt;
    logic [31:0]       pk_w;
    logic              sbit, sh_rot, sh_left, sh_right;

    // Inverted B feeds subtract and the -n logic ops
    assign opr_b_n = (op_sub || op_xorn || op_orn || op_andn) ? ~opr_b : opr_b;

    // ------------------------------------------------------------------------
    // Add, sub and compare
    // ------------------------------------------------------------------------

    assign add_out = opr_a + opr_b_n + xlen_t'(op_sub);
    assign add_res = word ? {{32{add_out[31]}}, add_out[31:0]} : add_out;

    assign cmp_eq  = (opr_a == opr_b);
    assign cmp_lt  = word ? ($signed(opr_a[31:0]) < $signed(opr_b[31:0])) :
                            ($signed(opr_a) < $signed(opr_b));
    assign cmp_ltu = word ? (opr_a[31:0] < opr_b[31:0]) : (opr_a < opr_b);
    assign slt_res = {{XL{1'b0}}, op_slt ? cmp_lt : cmp_ltu};

    assign bit_res = {XLEN{op_xor || op_xorn}} & (opr_a ^ opr_b_n) |
                     {XLEN{op_or  || op_orn }} & (opr_a | opr_b_n) |
                     {XLEN{op_and || op_andn}} & (opr_a & opr_b_n);

    // ------------------------------------------------------------------------
    // Shifts and rotates, result taken from the top half for left ops
    // ------------------------------------------------------------------------

    assign sbit     = op_sra && (word ? opr_a[31] : opr_a[XL]);
    assign sh_rot   = op_ror || op_rol;
    assign sh_left  = op_sll || op_rol;
    assign sh_right = op_srl || op_sra || op_ror;
    assign sh_amt   = {!word && shamt[5], shamt[4:0]};   // Word forms use 5 bits

    always_comb begin
        if (word) begin
            rsh_in = sh_rot ? {64'b0, opr_a[31:0], opr_a[31:0]} :
                              {64'b0, {32{sbit}}, opr_a[31:0]};
            lsh_in = sh_rot ? {64'b0, opr_a[31:0], opr_a[31:0]} :
                              {64'b0, opr_a[31:0], 32'b0};
        end else begin
            rsh_in = sh_rot ? {opr_a, opr_a} : {{XLEN{sbit}}, opr_a};
            lsh_in = sh_rot ? {opr_a, opr_a} : {opr_a, {XLEN{1'b0}}};
        end
    end

    assign rsh_out = rsh_in >> sh_amt;
    assign lsh_out = lsh_in << sh_amt;

    assign shift_res =
        {XLEN{sh_right &&  word}} & {{32{rsh_out[31]}}, rsh_out[31:0]}  |
        {XLEN{sh_right && !word}} & rsh_out[XL:0]                       |
        {XLEN{sh_left  &&  word}} & {{32{lsh_out[63]}}, lsh_out[63:32]} |
        {XLEN{sh_left  && !word}} & lsh_out[2*XLEN-1:XLEN];

    // Pack forms
    assign pk_w = op_packu ? {opr_b[31:16], opr_a[31:16]} : {opr_b[15:0], opr_a[15:0]};

    always_comb begin
        if (op_packh) begin
            pack_res = {48'b0, opr_b[7:0], opr_a[7:0]};
        end else if (word) begin
            pack_res = {{32{pk_w[31]}}, pk_w};
        end else if (op_packu) begin
            pack_res = {opr_b[63:32], opr_a[63:32]};
        end else begin
            pack_res = {opr_b[31:0], opr_a[31:0]};
        end
    end

    // Generalized reverse, only three patterns
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            for (int j = 0; j < 8; j++) begin
                grev_7[8*i + j] = opr_a[8*i + 7 - j];   // Bits in byte
            end
            grev_56[8*i +: 8] = opr_a[8*(7 - i) +: 8];  // Bytes in dword
            grev_24[8*i +: 8] = opr_a[8*(i ^ 3) +: 8];  // Bytes in each word
        end
    end

    assign grev_res = (shamt == 6'd7)  ? grev_7  :
                      (shamt == 6'd24) ? grev_24 :
                      (shamt == 6'd56) ? grev_56 : '0;

    // Crossbar permutations, B holds the lane indexes
    always_comb begin
        for (int n = 0; n < 16; n++) begin
            xpn_res[4*n +: 4] = opr_a[{opr_b[4*n +: 4], 2'b00} +: 4];
        end
        for (int b = 0; b < 8; b++) begin
            xpb_res[8*b +: 8] = (opr_b[8*b + 3 +: 5] != 5'd0) ? 8'h00 :
                                opr_a[{opr_b[8*b +: 3], 3'b000} +: 8];
        end
    end

    assign result =
                                                       bit_res   |
        {XLEN{op_add  || op_sub}}                    & add_res   |
        {XLEN{op_slt  || op_sltu}}                   & slt_res   |
        {XLEN{sh_left || sh_right}}                  & shift_res |
        {XLEN{op_pack || op_packu || op_packh}}      & pack_res  |
        {XLEN{op_grev}}                              & grev_res  |
        {XLEN{op_xpermn}}                            & xpn_res   |
        {XLEN{op_xpermb}}                            & xpb_res;

endmodule

//--- logic/core_pkg.sv
/*
 * Integer execute path package
 * Widths, ALU opcodes, decoded select lines and queue sizing shared
 * by the decoder, request queue and execute stage
 */
package core_pkg;

    localparam int XLEN        = 64;           // Datapath width
    localparam int XL          = XLEN - 1;     // Top bit index
    localparam int TAG_W       = 4;
    localparam int QUEUE_DEPTH = 4;            // Request queue entries
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);

    typedef logic [XL:0]      xlen_t;
    typedef logic [TAG_W-1:0] tag_t;

    // Opcodes seen at the top level
    typedef enum logic [4:0] {
        ALU_ADD    = 5'd0,
        ALU_SUB    = 5'd1,
        ALU_SLT    = 5'd2,
        ALU_SLTU   = 5'd3,
        ALU_XOR    = 5'd4,
        ALU_OR     = 5'd5,
        ALU_AND    = 5'd6,
        ALU_XORN   = 5'd7,
        ALU_ORN    = 5'd8,
        ALU_ANDN   = 5'd9,
        ALU_SLL    = 5'd10,
        ALU_SRL    = 5'd11,
        ALU_SRA    = 5'd12,
        ALU_ROL    = 5'd13,
        ALU_ROR    = 5'd14,
        ALU_PACK   = 5'd15,
        ALU_PACKU  = 5'd16,
        ALU_PACKH  = 5'd17,
        ALU_GREV   = 5'd18,
        ALU_XPERMN = 5'd19,
        ALU_XPERMB = 5'd20
    } alu_op_e;

    // One-hot selects in the order of the ALU ports
    typedef struct packed {
        logic op_add;
        logic op_sub;
        logic op_xor;
        logic op_or;
        logic op_and;
        logic op_slt;
        logic op_sltu;
        logic op_srl;
        logic op_sll;
        logic op_sra;
        logic op_xorn;
        logic op_andn;
        logic op_orn;
        logic op_ror;
        logic op_rol;
        logic op_pack;
        logic op_packh;
        logic op_packu;
        logic op_grev;
        logic op_xpermn;
        logic op_xpermb;
        logic word;        // Low 32 bits, sign extended
    } alu_sel_t;

    typedef struct packed {
        alu_sel_t   sel;
        xlen_t      opr_a;
        xlen_t      opr_b;
        logic [5:0] shamt;
        tag_t       tag;
    } alu_req_t;

    typedef struct packed {
        logic eq;
        logic lt;
        logic ltu;
    } cmp_flags_t;

endpackage

//--- logic/core_req_queue.sv
/*
 * Decoded request queue
 * Circular FIFO of QUEUE_DEPTH decoded requests between decoder and
 * execute stage
 */
module core_req_queue
    import core_pkg::*;
(
    input  logic          g_clk,
    input  logic          rst,
    alu_req_if.consumer   push,
    alu_req_if.producer   pop
);

    alu_req_t          mem [QUEUE_DEPTH];
    logic [QPTR_W-1:0] wr_ptr;
    logic [QPTR_W-1:0] rd_ptr;
    logic [QCNT_W-1:0] count;     // Entries held
    logic              do_push;
    logic              do_pop;

    function automatic logic [QPTR_W-1:0] ptr_inc(input logic [QPTR_W-1:0] p);
        return (p == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign push.ready = (count != QCNT_W'(QUEUE_DEPTH));   // Low only when full
    assign pop.valid  = (count != '0);
    assign pop.req    = mem[rd_ptr];

    assign do_push = push.valid && push.ready;
    assign do_pop  = pop.valid && pop.ready;

    // ------------------------------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------------------------------

    always_ff @(posedge g_clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Both or neither
            endcase
        end
    end

    // Storage
    always_ff @(posedge g_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push.req;
        end
    end

endmodule

//--- verif/core_exec_unit_assertions.sv
/*
 * Execute unit handshake assertions
 * Reset values, output hold under back-pressure and result ordering
 */
module core_exec_unit_assertions
    import core_pkg::*;
(
    input logic       g_clk,
    input logic       rst,
    input logic       in_valid,
    input logic       in_ready,
    input logic       out_valid,
    input logic       out_ready,
    input xlen_t      out_result,
    input xlen_t      out_add,
    input cmp_flags_t out_flags,
    input tag_t       out_tag
);

    int unsigned in_cnt;    // Accepted requests
    int unsigned out_cnt;   // Delivered results

    always_ff @(posedge g_clk) begin
        if (rst) begin
            in_cnt  <= 0;
            out_cnt <= 0;
        end else begin
            in_cnt  <= in_cnt + ((in_valid && in_ready) ? 1 : 0);
            out_cnt <= out_cnt + ((out_valid && out_ready) ? 1 : 0);
        end
    end

    a_reset_values: assert property (@(posedge g_clk) rst |=> !out_valid && in_ready)
        else $error("out_valid or in_ready left its reset value during reset");

    a_out_hold: assert property (@(posedge g_clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_result) && $stable(out_add) &&
                                    $stable(out_flags) && $stable(out_tag))
        else $error("output changed while out_ready was low");

    a_out_after_in: assert property (@(posedge g_clk) disable iff (rst)
        out_valid |-> in_cnt > out_cnt)
        else $error("result presented without an accepted request");

endmodule

bind core_exec_unit core_exec_unit_assertions core_exec_unit_assertions_inst (.*);

//--- verif/tb_core_exec_unit.sv
/*
 * Testbench for the integer execute unit
 * Directed and random ALU requests checked against a reference model,
 * with an in-order scoreboard and random output back-pressure
 */
module tb_core_exec_unit
    import core_pkg::*;
();

    localparam int RST_CYCLES = 8;
    localparam int N_ARITH    = 40;     // 4 ops x 2 word modes x 5 pairs
    localparam int N_LOGIC    = 74;     // 6 ops x 4 pairs plus 5 shifts x 5 amounts x 2
    localparam int N_BITMANIP = 24;
    localparam int N_RAND     = 200;
    localparam int N_REQ      = N_ARITH + N_LOGIC + N_BITMANIP + N_RAND;
    localparam int TIMEOUT_CYCLES = 40 * N_REQ + 200;

    typedef struct packed {
        xlen_t      result;
        xlen_t      add;
        cmp_flags_t flags;
        tag_t       tag;
    } exp_t;

    logic       g_clk;
    logic       rst;
    logic       in_valid;
    logic       in_ready;
    alu_op_e    in_op;
    xlen_t      in_opr_a;
    xlen_t      in_opr_b;
    logic [5:0] in_shamt;
    logic       in_word;
    tag_t       in_tag;
    logic       out_valid;
    logic       out_ready;
    xlen_t      out_result;
    xlen_t      out_add;
    cmp_flags_t out_flags;
    tag_t       out_tag;

    exp_t   exp_q [$];        // Results still owed by the DUT
    exp_t   expd;
    integer seed;
    int     rnd_bp;
    int     n_checks;
    int     n_errors;
    int     chk_mark;
    int     err_mark;
    int     cycle_cnt;
    tag_t   next_tag;
    logic   bp_mode;          // Random out_ready when set
    logic   full_seen;

    xlen_t bnd_a [5] = '{64'h0, 64'h0000_0000_7fff_ffff, 64'h8000_0000_0000_0000,
                         64'hffff_ffff_ffff_ffff, 64'h0000_0000_8000_0000};
    xlen_t bnd_b [5] = '{64'h0, 64'h0000_0000_0000_0001, 64'h0000_0000_0000_0001,
                         64'h7fff_ffff_ffff_ffff, 64'h0000_0000_7fff_ffff};

    core_exec_unit core_exec_unit_inst (.*);

    always #50 g_clk = ~g_clk;

    // -------------------------------------------------------------------------
    // Reference model
    // -------------------------------------------------------------------------

    function automatic xlen_t sext32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    // Staged generalized reverse with one swap per shamt bit
    function automatic xlen_t grev64(input xlen_t x, input logic [5:0] k);
        if (k[0]) x = ((x & 64'h5555_5555_5555_5555) << 1) | ((x & 64'haaaa_aaaa_aaaa_aaaa) >> 1);
        if (k[1]) x = ((x & 64'h3333_3333_3333_3333) << 2) | ((x & 64'hcccc_cccc_cccc_cccc) >> 2);
        if (k[2]) x = ((x & 64'h0f0f_0f0f_0f0f_0f0f) << 4) | ((x & 64'hf0f0_f0f0_f0f0_f0f0) >> 4);
        if (k[3]) x = ((x & 64'h00ff_00ff_00ff_00ff) << 8) | ((x & 64'hff00_ff00_ff00_ff00) >> 8);
        if (k[4]) x = ((x & 64'h0000_ffff_0000_ffff) << 16) | ((x & 64'hffff_0000_ffff_0000) >> 16);
        if (k[5]) x = (x << 32) | (x >> 32);
        return x;
    endfunction

    function automatic exp_t alu_model(input alu_op_e op, input xlen_t a, input xlen_t b,
                                       input logic [5:0] sh, input logic word, input tag_t tag);
        exp_t        e;
        logic        w;
        logic [31:0] a32;
        logic [31:0] r32;
        int          s;
        int          idx;
        w   = word && (op inside {ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA,
                                  ALU_ROL, ALU_ROR, ALU_PACK, ALU_PACKU});
        a32 = a[31:0];
        s   = w ? int'(sh[4:0]) : int'(sh);
        e.tag = tag;
        if (op == ALU_SUB) e.add = a - b;
        else if (op inside {ALU_XORN, ALU_ORN, ALU_ANDN}) e.add = a + ~b;
        else e.add = a + b;
        e.flags.eq  = (a == b);
        e.flags.lt  = w ? ($signed(a32) < $signed(b[31:0])) : ($signed(a) < $signed(b));
        e.flags.ltu = w ? (a32 < b[31:0]) : (a < b);
        e.result = '0;
        case (op)
            ALU_ADD:  e.result = w ? sext32(a32 + b[31:0]) : a + b;
            ALU_SUB:  e.result = w ? sext32(a32 - b[31:0]) : a - b;
            ALU_SLT:  e.result = xlen_t'($signed(a) < $signed(b));
            ALU_SLTU: e.result = xlen_t'(a < b);
            ALU_XOR:  e.result = a ^ b;
            ALU_OR:   e.result = a | b;
            ALU_AND:  e.result = a & b;
            ALU_XORN: e.result = a ^ ~b;
            ALU_ORN:  e.result = a | ~b;
            ALU_ANDN: e.result = a & ~b;
            ALU_SLL:  e.result = w ? sext32(a32 << s) : a << s;
            ALU_SRL:  e.result = w ? sext32(a32 >> s) : a >> s;
            ALU_SRA: begin
                r32 = $signed(a32) >>> s;
                e.result = w ? sext32(r32) : xlen_t'($signed(a) >>> s);
            end
            ALU_ROL: begin
                r32 = (a32 << s) | (a32 >> (32 - s));
                e.result = w ? sext32(r32) : (a << s) | (a >> (64 - s));
            end
            ALU_ROR: begin
                r32 = (a32 >> s) | (a32 << (32 - s));
                e.result = w ? sext32(r32) : (a >> s) | (a << (64 - s));
            end
            ALU_PACK:  e.result = w ? sext32({b[15:0], a[15:0]}) : {b[31:0], a[31:0]};
            ALU_PACKU: e.result = w ? sext32({b[31:16], a[31:16]}) : {b[63:32], a[63:32]};
            ALU_PACKH: e.result = {48'b0, b[7:0], a[7:0]};
            ALU_GREV:  e.result = (sh inside {6'd7, 6'd24, 6'd56}) ? grev64(a, sh) : '0;
            ALU_XPERMN: begin
                for (int i = 0; i < 16; i++) begin
                    idx = int'(b[4*i +: 4]);
                    e.result[4*i +: 4] = a[4*idx +: 4];
                end
            end
            ALU_XPERMB: begin
                for (int i = 0; i < 8; i++) begin
                    idx = int'(b[8*i +: 8]);
                    if (idx < 8) e.result[8*i +: 8] = a[8*idx +: 8];
                end
            end
            default: e.result = '0;
        endcase
        return e;
    endfunction

    // -------------------------------------------------------------------------
    // Compare tasks
    // -------------------------------------------------------------------------

    task automatic check_result(input string name, input xlen_t got, input xlen_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_flags(input string name, input cmp_flags_t got, input cmp_flags_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_tag(input string name, input tag_t got, input tag_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_ctrl(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    // Scoreboard sampled mid-cycle where all signals are settled
    always @(negedge g_clk) begin
        if (!rst) begin
            if (!in_ready) begin
                full_seen = 1'b1;
                if (exp_q.size() < QUEUE_DEPTH + 1) begin
                    n_errors++;
                    $display("in_ready low with only %0d requests pending", exp_q.size());
                end
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    n_errors++;
                    $display("result delivered with no request pending");
                end else begin
                    expd = exp_q.pop_front();
                    check_result("out_result", out_result, expd.result);
                    check_result("out_add", out_add, expd.add);
                    check_flags("out_flags", out_flags, expd.flags);
                    check_tag("out_tag", out_tag, expd.tag);
                end
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(alu_model(in_op, in_opr_a, in_opr_b, in_shamt, in_word, in_tag));
            end
        end
    end

    // Back-pressure pattern drawn at the edge, driven after the edge
    always @(posedge g_clk) begin
        rnd_bp = bp_mode ? $random(seed) : 1;
        #10;
        out_ready = rnd_bp[0];
    end

    always @(posedge g_clk) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d results outstanding", cycle_cnt, exp_q.size());
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // -------------------------------------------------------------------------
    // Stimulus
    // -------------------------------------------------------------------------

    function automatic xlen_t rand64();
        return {$random(seed), $random(seed)};
    endfunction

    // Called and returns 10 units after a rising edge
    task automatic send_req(input alu_op_e op, input xlen_t a, input xlen_t b,
                            input logic [5:0] sh, input logic word);
        in_valid = 1'b1;
        in_op    = op;
        in_opr_a = a;
        in_opr_b = b;
        in_shamt = sh;
        in_word  = word;
        in_tag   = next_tag;
        @(negedge g_clk);
        while (!in_ready) @(negedge g_clk);
        @(posedge g_clk);
        #10;
        in_valid = 1'b0;
        next_tag = next_tag + 1'b1;
    endtask

    task automatic wait_drain();
        @(posedge g_clk);
        while (exp_q.size() != 0) @(posedge g_clk);
        #10;
    endtask

    task automatic report_test(input string name);
        $display("test %s: %0d checks, %0d errors", name, n_checks - chk_mark, n_errors - err_mark);
        chk_mark = n_checks;
        err_mark = n_errors;
    endtask

    task automatic reset_test();
        rst = 1'b1;
        repeat (RST_CYCLES - 1) begin
            @(posedge g_clk);
            @(negedge g_clk);
            check_ctrl("out_valid", out_valid, 1'b0);
            check_ctrl("in_ready", in_ready, 1'b1);
        end
        @(posedge g_clk);
        #10;
        rst = 1'b0;
        @(negedge g_clk);
        check_ctrl("out_valid", out_valid, 1'b0);   // First cycle out of reset
        check_ctrl("in_ready", in_ready, 1'b1);
        @(posedge g_clk);
        #10;
        report_test("reset");
    endtask

    task automatic arith_test();
        alu_op_e ops [4] = '{ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU};
        for (int k = 0; k < 4; k++)
            for (int w = 0; w < 2; w++)
                for (int i = 0; i < 5; i++)
                    send_req(ops[k], bnd_a[i], bnd_b[i], 6'd0, w[0]);
        wait_drain();
        report_test("arith");
    endtask

    task automatic logic_test();
        alu_op_e    log_ops [6] = '{ALU_XOR, ALU_OR, ALU_AND, ALU_XORN, ALU_ORN, ALU_ANDN};
        alu_op_e    sh_ops  [5] = '{ALU_SLL, ALU_SRL, ALU_SRA, ALU_ROL, ALU_ROR};
        logic [5:0] amts    [5] = '{6'd0, 6'd1, 6'd31, 6'd32, 6'd63};
        for (int k = 0; k < 6; k++)
            for (int i = 1; i < 5; i++)
                send_req(log_ops[k], bnd_a[i], bnd_b[(i + 2) % 5] ^ rand64(), 6'd0, i[0]);
        for (int k = 0; k < 5; k++)
            for (int j = 0; j < 5; j++)
                for (int w = 0; w < 2; w++)
                    send_req(sh_ops[k], 64'h8123_4567_89ab_cdef, rand64(), amts[j], w[0]);
        wait_drain();
        report_test("logic");
    endtask

    task automatic bitmanip_test();
        alu_op_e    pk_ops [3] = '{ALU_PACK, ALU_PACKU, ALU_PACKH};
        logic [5:0] grev_amts [4] = '{6'd7, 6'd24, 6'd56, 6'd13};   // 13 is unsupported
        for (int k = 0; k < 3; k++) begin
            for (int w = 0; w < 2; w++) begin
                send_req(pk_ops[k], 64'h0123_4567_89ab_cdef, 64'hfedc_ba98_7654_3210, 6'd0, w[0]);
                send_req(pk_ops[k], 64'h8000_7fff_ffff_8001, 64'h7fff_8000_0000_ffff, 6'd0, w[0]);
            end
        end
        for (int k = 0; k < 4; k++) begin
            send_req(ALU_GREV, 64'h0123_4567_89ab_cdef, rand64(), grev_amts[k], 1'b0);
            send_req(ALU_GREV, rand64(), rand64(), grev_amts[k], 1'b1);
        end
        send_req(ALU_XPERMN, 64'h0123_4567_89ab_cdef, 64'h0123_4567_89ab_cdef, 6'd0, 1'b0);
        send_req(ALU_XPERMN, rand64(), rand64(), 6'd0, 1'b0);
        send_req(ALU_XPERMB, 64'h0123_4567_89ab_cdef, 64'h08ff_0007_1003_8001, 6'd0, 1'b0);
        send_req(ALU_XPERMB, rand64(), rand64(), 6'd0, 1'b0);
        wait_drain();
        report_test("bitmanip");
    endtask

    task automatic order_test();
        int unsigned r;
        int unsigned r2;
        full_seen = 1'b0;
        bp_mode   = 1'b1;
        for (int i = 0; i < N_RAND; i++) begin
            r  = $random(seed);
            r2 = $random(seed);
            send_req(alu_op_e'(5'(r % 21)), rand64(), rand64(), r2[5:0], r2[8]);
        end
        bp_mode = 1'b0;
        wait_drain();
        if (!full_seen) begin
            n_errors++;
            $display("in_ready never dropped while results were held back");
        end
        report_test("order");
    endtask

    initial begin
        g_clk     = 1'b0;
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_op     = ALU_ADD;
        in_opr_a  = '0;
        in_opr_b  = '0;
        in_shamt  = '0;
        in_word   = 1'b0;
        in_tag    = '0;
        out_ready = 1'b1;
        bp_mode   = 1'b0;
        full_seen = 1'b0;
        next_tag  = '0;
        seed      = 32'hbd397fbc;
        n_checks  = 0;
        n_errors  = 0;
        chk_mark  = 0;
        err_mark  = 0;
        cycle_cnt = 0;
        reset_test();
        arith_test();
        logic_test();
        bitmanip_test();
        order_test();
        $display("total: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
